//--- rtl/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int wordWidth   = 32;
    localparam int numRegs     = 16;
    localparam int regIdxWidth = $clog2(numRegs);
    localparam int constWidth  = 19;

    // Opcode sits in instruction bits 31 to 27
    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opAddi = 5'b01100,
        opMul  = 5'b01110,
        opIn   = 5'b10110,
        opOut  = 5'b10111,
        opMfhi = 5'b11000,
        opMflo = 5'b11001,
        opHalt = 5'b11011
    } opcodeT;

    // Register format view of the low 19 bits
    typedef struct packed {
        logic [regIdxWidth-1:0]            rc;
        logic [constWidth-regIdxWidth-1:0] spare;
    } regTailT;

    // rc overlaps the top of the constant
    typedef union packed {
        regTailT               fmt;
        logic [constWidth-1:0] constant;
    } tailT;

    typedef struct packed {
        opcodeT                 opcode;
        logic [regIdxWidth-1:0] ra;
        logic [regIdxWidth-1:0] rb;
        tailT                   tail;
    } instrT;

endpackage

`default_nettype wire

//--- rtl/datapathPkg.sv
`default_nettype none

package datapathPkg;

    // Source that drives the shared bus
    typedef enum logic [3:0] {
        srcGpReg,
        srcHi,
        srcLo,
        srcZHigh,
        srcZLow,
        srcPc,
        srcMdr,
        srcInPort,
        srcConst
    } busSrcT;

    // incPc passes B plus one
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluMul,
        aluIncPc
    } aluOpT;

    typedef struct packed {
        busSrcT busSrc;
        logic   gra;
        logic   grb;
        logic   grc;
        logic   rIn;
        logic   rOut;
        logic   baOut;
        logic   marIn;
        logic   mdrIn;
        logic   memRead;
        logic   memWrite;
        logic   yIn;
        logic   zIn;
        logic   pcIn;
        logic   irIn;
        logic   hiIn;
        logic   loIn;
        logic   inPortIn;
        logic   outPortIn;
        aluOpT  aluOp;
    } ctrlWordT;

endpackage

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [isaPkg::wordWidth-1:0]   a,
    input  logic [isaPkg::wordWidth-1:0]   b,
    input  datapathPkg::aluOpT             op,
    output logic [2*isaPkg::wordWidth-1:0] result
);
    import isaPkg::*;
    import datapathPkg::*;

    logic signed [2*wordWidth-1:0] product;
    logic        [wordWidth-1:0]   low;

    // Both operands sign-extended to the full product width
    assign product = $signed({{wordWidth{a[wordWidth-1]}}, a})
                   * $signed({{wordWidth{b[wordWidth-1]}}, b});

    always_comb begin
        case (op)
            aluAdd:   low = a + b;
            aluSub:   low = a - b;
            aluAnd:   low = a & b;
            aluOr:    low = a | b;
            aluIncPc: low = b + wordWidth'(1);
            default:  low = '0;
        endcase
    end

    // Upper half only carries data for multiply
    assign result = (op == aluMul) ? product : {{wordWidth{1'b0}}, low};

endmodule

`default_nettype wire

//--- rtl/selectEncode.sv
`timescale 1ns/1ps
`default_nettype none

module selectEncode (
    input  isaPkg::instrT                ir,
    input  logic                         gra,
    input  logic                         grb,
    input  logic                         grc,
    input  logic                         rIn,
    input  logic                         rOut,
    output logic [isaPkg::numRegs-1:0]   regWe,
    output logic [isaPkg::numRegs-1:0]   regRe,
    output logic [isaPkg::wordWidth-1:0] constExt
);
    import isaPkg::*;

    logic [regIdxWidth-1:0] field;
    logic [numRegs-1:0]     decoded;

    // Register field picked by the control step
    assign field = ({regIdxWidth{gra}} & ir.ra)
                 | ({regIdxWidth{grb}} & ir.rb)
                 | ({regIdxWidth{grc}} & ir.tail.fmt.rc);

    assign decoded = numRegs'(1) << field;
    assign regWe   = rIn ? decoded : '0;
    assign regRe   = rOut ? decoded : '0;

    assign constExt = {{(wordWidth - constWidth){ir.tail.constant[constWidth-1]}},
                       ir.tail.constant};

    // A control step names a single register field
    always_comb begin
        assert ($onehot0({gra, grb, grc}))
            else $error("more than one register field selected");
    end

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [isaPkg::numRegs-1:0]   regWe,
    input  logic [isaPkg::numRegs-1:0]   regRe,
    input  logic [isaPkg::wordWidth-1:0] busIn,
    output logic [isaPkg::wordWidth-1:0] regOut
);
    import isaPkg::*;

    logic [wordWidth-1:0] regs [numRegs];

    for (genvar i = 0; i < numRegs; i++) begin : gpReg
        always_ff @(posedge clk) begin
            if (rst) begin
                regs[i] <= '0;
            end else if (regWe[i]) begin
                regs[i] <= busIn;
            end
        end
    end

    // One-hot read, OR of the selected register
    always_comb begin
        regOut = '0;
        for (int i = 0; i < numRegs; i++) begin
            if (regRe[i]) regOut = regOut | regs[i];
        end
    end

    regReadOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(regRe))
        else $error("several general registers drive the bus");

endmodule

`default_nettype wire

//--- rtl/memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory #(
    parameter int memDepth = 512
) (
    input  logic                         clk,
    input  logic [$clog2(memDepth)-1:0]  addr,
    input  logic [isaPkg::wordWidth-1:0] wrData,
    input  logic                         read,
    input  logic                         write,
    output logic [isaPkg::wordWidth-1:0] rdData,
    input  logic                         progWe,
    input  logic [$clog2(memDepth)-1:0]  progAddr,
    input  logic [isaPkg::wordWidth-1:0] progData,
    input  logic                         busy
);
    import isaPkg::*;

    logic [wordWidth-1:0] mem [memDepth];

    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end else if (write) begin
            mem[addr] <= wrData;
        end
        if (read) rdData <= mem[addr];
    end

    // Program loads stay clear of core memory traffic
    progLoadIdle: assert property (@(posedge clk) !(progWe && busy))
        else $error("program load while the core uses memory");

endmodule

`default_nettype wire

//--- rtl/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,
    input  isaPkg::instrT         ir,
    output datapathPkg::ctrlWordT ctrl,
    output logic                  done,
    output logic                  outValid
);
    import isaPkg::*;
    import datapathPkg::*;

    typedef enum logic [1:0] {sIdle, sFetch, sExec, sHalted} stateT;

    stateT      state;
    logic [2:0] step;
    logic [2:0] lastStep;
    aluOpT      aluSel;

    // Final execute step per opcode
    always_comb begin
        case (ir.opcode)
            opAdd, opSub, opAnd, opOr, opAddi: lastStep = 3'd2;
            opMul, opSt:                       lastStep = 3'd3;
            opLd:                              lastStep = 3'd4;
            default:                           lastStep = 3'd0;
        endcase
    end

    always_comb begin
        case (ir.opcode)
            opSub:   aluSel = aluSub;
            opAnd:   aluSel = aluAnd;
            opOr:    aluSel = aluOr;
            opMul:   aluSel = aluMul;
            default: aluSel = aluAdd;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= sIdle;
            step     <= '0;
            outValid <= 1'b0;
        end else begin
            // Port register is loaded at the end of the outPortIn step
            outValid <= ctrl.outPortIn;
            case (state)
                sIdle, sHalted: begin
                    if (run) begin
                        state <= sFetch;
                        step  <= '0;
                    end
                end
                sFetch: begin
                    if (step == 3'd2) begin
                        state <= sExec;
                        step  <= '0;
                    end else begin
                        step <= step + 3'd1;
                    end
                end
                default: begin
                    if (step == lastStep) begin
                        state <= (ir.opcode == opHalt) ? sHalted : sFetch;
                        step  <= '0;
                    end else begin
                        step <= step + 3'd1;
                    end
                end
            endcase
        end
    end

    assign done = (state == sHalted);

    always_comb begin
        ctrl = '0;
        case (state)
            sIdle, sHalted: begin
                // No register selected, so the bus carries zero into PC
                ctrl.pcIn = run;
            end
            sFetch: begin
                case (step)
                    3'd0: begin
                        ctrl.busSrc  = srcPc;
                        ctrl.marIn   = 1'b1;
                        ctrl.memRead = 1'b1;
                        ctrl.aluOp   = aluIncPc;
                        ctrl.zIn     = 1'b1;
                    end
                    3'd1: begin
                        ctrl.busSrc  = srcZLow;
                        ctrl.pcIn    = 1'b1;
                        ctrl.memRead = 1'b1;
                        ctrl.mdrIn   = 1'b1;
                    end
                    default: begin
                        ctrl.busSrc   = srcMdr;
                        ctrl.irIn     = 1'b1;
                        // Input port sampled once per instruction
                        ctrl.inPortIn = 1'b1;
                    end
                endcase
            end
            sExec: begin
                case (ir.opcode)
                    opAdd, opSub, opAnd, opOr, opAddi, opMul: begin
                        case (step)
                            3'd0: begin
                                ctrl.grb  = 1'b1;
                                ctrl.rOut = 1'b1;
                                ctrl.yIn  = 1'b1;
                            end
                            3'd1: begin
                                if (ir.opcode == opAddi) begin
                                    ctrl.busSrc = srcConst;
                                end else begin
                                    ctrl.grc  = 1'b1;
                                    ctrl.rOut = 1'b1;
                                end
                                ctrl.aluOp = aluSel;
                                ctrl.zIn   = 1'b1;
                            end
                            3'd2: begin
                                if (ir.opcode == opMul) begin
                                    ctrl.busSrc = srcZHigh;
                                    ctrl.hiIn   = 1'b1;
                                end else begin
                                    ctrl.busSrc = srcZLow;
                                    ctrl.gra    = 1'b1;
                                    ctrl.rIn    = 1'b1;
                                end
                            end
                            default: begin
                                ctrl.busSrc = srcZLow;
                                ctrl.loIn   = 1'b1;
                            end
                        endcase
                    end
                    opLd, opSt: begin
                        case (step)
                            3'd0: begin
                                ctrl.grb   = 1'b1;
                                ctrl.rOut  = 1'b1;
                                ctrl.baOut = 1'b1;
                                ctrl.yIn   = 1'b1;
                            end
                            3'd1: begin
                                ctrl.busSrc = srcConst;
                                ctrl.aluOp  = aluAdd;
                                ctrl.zIn    = 1'b1;
                            end
                            3'd2: begin
                                if (ir.opcode == opSt) begin
                                    ctrl.gra   = 1'b1;
                                    ctrl.rOut  = 1'b1;
                                    ctrl.mdrIn = 1'b1;
                                end else begin
                                    ctrl.busSrc  = srcZLow;
                                    ctrl.marIn   = 1'b1;
                                    ctrl.memRead = 1'b1;
                                end
                            end
                            3'd3: begin
                                if (ir.opcode == opSt) begin
                                    ctrl.busSrc   = srcZLow;
                                    ctrl.marIn    = 1'b1;
                                    ctrl.memWrite = 1'b1;
                                end else begin
                                    ctrl.memRead = 1'b1;
                                    ctrl.mdrIn   = 1'b1;
                                end
                            end
                            default: begin
                                ctrl.busSrc = srcMdr;
                                ctrl.gra    = 1'b1;
                                ctrl.rIn    = 1'b1;
                            end
                        endcase
                    end
                    opMfhi, opMflo, opIn: begin
                        case (ir.opcode)
                            opMfhi:  ctrl.busSrc = srcHi;
                            opMflo:  ctrl.busSrc = srcLo;
                            default: ctrl.busSrc = srcInPort;
                        endcase
                        ctrl.gra = 1'b1;
                        ctrl.rIn = 1'b1;
                    end
                    opOut: begin
                        ctrl.gra       = 1'b1;
                        ctrl.rOut      = 1'b1;
                        ctrl.outPortIn = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter int memDepth = 512
) (
    input  logic                         clk,
    input  logic                         rst,
    input  datapathPkg::ctrlWordT        ctrl,
    input  logic [isaPkg::wordWidth-1:0] inPortData,
    input  logic [isaPkg::wordWidth-1:0] memRdData,
    output isaPkg::instrT                ir,
    output logic [$clog2(memDepth)-1:0]  memAddr,
    output logic [isaPkg::wordWidth-1:0] memWrData,
    output logic [isaPkg::wordWidth-1:0] outPortData
);
    import isaPkg::*;
    import datapathPkg::*;

    localparam int addrWidth = $clog2(memDepth);

    logic [wordWidth-1:0]   bus;
    logic [wordWidth-1:0]   pc, mdr, y, hi, lo, inPort, outPort;
    logic [2*wordWidth-1:0] z;
    logic [addrWidth-1:0]   mar;
    logic [numRegs-1:0]     regWe, regRe;
    logic [wordWidth-1:0]   regOut, gpValue, constExt;
    logic [2*wordWidth-1:0] aluResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            ir      <= '0;
            mar     <= '0;
            mdr     <= '0;
            y       <= '0;
            z       <= '0;
            hi      <= '0;
            lo      <= '0;
            inPort  <= '0;
            outPort <= '0;
        end else begin
            if (ctrl.pcIn) pc <= bus;
            if (ctrl.irIn) ir <= bus;
            if (ctrl.marIn) mar <= bus[addrWidth-1:0];
            // MDR takes memory data on reads, the bus otherwise
            if (ctrl.mdrIn) mdr <= ctrl.memRead ? memRdData : bus;
            if (ctrl.yIn) y <= bus;
            if (ctrl.zIn) z <= aluResult;
            if (ctrl.hiIn) hi <= bus;
            if (ctrl.loIn) lo <= bus;
            if (ctrl.inPortIn) inPort <= inPortData;
            if (ctrl.outPortIn) outPort <= bus;
        end
    end

    // R0 as a base address reads as zero
    assign gpValue = (ctrl.baOut && regRe[0]) ? '0 : regOut;

    always_comb begin
        case (ctrl.busSrc)
            srcHi:     bus = hi;
            srcLo:     bus = lo;
            srcZHigh:  bus = z[2*wordWidth-1:wordWidth];
            srcZLow:   bus = z[wordWidth-1:0];
            srcPc:     bus = pc;
            srcMdr:    bus = mdr;
            srcInPort: bus = inPort;
            srcConst:  bus = constExt;
            default:   bus = gpValue;
        endcase
    end

    // Memory sees the address MAR is about to take
    assign memAddr     = ctrl.marIn ? bus[addrWidth-1:0] : mar;
    assign memWrData   = mdr;
    assign outPortData = outPort;

    selectEncode selectEncode_inst (
        .ir       (ir),
        .gra      (ctrl.gra),
        .grb      (ctrl.grb),
        .grc      (ctrl.grc),
        .rIn      (ctrl.rIn),
        .rOut     (ctrl.rOut),
        .regWe    (regWe),
        .regRe    (regRe),
        .constExt (constExt)
    );

    regFile regFile_inst (
        .clk    (clk),
        .rst    (rst),
        .regWe  (regWe),
        .regRe  (regRe),
        .busIn  (bus),
        .regOut (regOut)
    );

    alu alu_inst (
        .a      (y),
        .b      (bus),
        .op     (ctrl.aluOp),
        .result (aluResult)
    );

endmodule

`default_nettype wire

//--- rtl/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
    parameter int memDepth = 512
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         run,
    input  logic                         progWe,
    input  logic [$clog2(memDepth)-1:0]  progAddr,
    input  logic [isaPkg::wordWidth-1:0] progData,
    input  logic [isaPkg::wordWidth-1:0] inPortData,
    output logic [isaPkg::wordWidth-1:0] outPortData,
    output logic                         outValid,
    output logic                         done
);
    import isaPkg::*;
    import datapathPkg::*;

    ctrlWordT                    ctrl;
    instrT                       ir;
    logic [$clog2(memDepth)-1:0] memAddr;
    logic [wordWidth-1:0]        memWrData;
    logic [wordWidth-1:0]        memRdData;
    logic                        busy;

    assign busy = ctrl.memRead | ctrl.memWrite;

    controlUnit controlUnit_inst (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .ir       (ir),
        .ctrl     (ctrl),
        .done     (done),
        .outValid (outValid)
    );

    datapath #(
        .memDepth (memDepth)
    ) datapath_inst (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl),
        .inPortData  (inPortData),
        .memRdData   (memRdData),
        .ir          (ir),
        .memAddr     (memAddr),
        .memWrData   (memWrData),
        .outPortData (outPortData)
    );

    memory #(
        .memDepth (memDepth)
    ) memory_inst (
        .clk      (clk),
        .addr     (memAddr),
        .wrData   (memWrData),
        .read     (ctrl.memRead),
        .write    (ctrl.memWrite),
        .rdData   (memRdData),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .busy     (busy)
    );

endmodule

`default_nettype wire

//--- testbench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Reset released on a rising edge, like any other stimulus
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
    import isaPkg::*;

    localparam int memDepth   = 512;
    localparam int addrWidth  = $clog2(memDepth);
    localparam int periodNs   = 8;
    localparam int maxProg    = 64;
    localparam int numRuns    = 6;
    // Budget of 8 cycles per instruction over every run
    localparam int watchdogNs = numRuns * maxProg * 8 * periodNs + 5000;

    logic                 clk;
    logic                 rst;
    logic                 run;
    logic                 progWe;
    logic [addrWidth-1:0] progAddr;
    logic [31:0]          progData;
    logic [31:0]          inPortData;
    logic [31:0]          outPortData;
    logic                 outValid;
    logic                 done;

    logic [31:0] prog [maxProg];
    int          progLen;
    logic [31:0] shadowMem [memDepth];
    logic [31:0] modelRegs [numRegs];
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    logic [31:0] expected [$];
    logic [31:0] rngState;
    logic [31:0] want;
    int          cmpChecks;
    int          cmpErrors;
    int          mainChecks;
    int          mainErrors;
    int          testCount;
    int          startErrors;

    clockGen #(
        .periodNs    (periodNs),
        .resetCycles (3)
    ) clockGen_inst (
        .clk (clk),
        .rst (rst)
    );

    cpuTop #(
        .memDepth (memDepth)
    ) cpuTop_inst (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .progWe      (progWe),
        .progAddr    (progAddr),
        .progData    (progData),
        .inPortData  (inPortData),
        .outPortData (outPortData),
        .outValid    (outValid),
        .done        (done)
    );

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] regInstr(opcodeT op, logic [3:0] ra, logic [3:0] rb,
                                             logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic logic [31:0] immInstr(opcodeT op, logic [3:0] ra, logic [3:0] rb,
                                             logic [18:0] c);
        return {op, ra, rb, c};
    endfunction

    function automatic logic [31:0] signExtend(logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    function automatic void emit(logic [31:0] word);
        if (progLen < maxProg) begin
            prog[progLen] = word;
            progLen++;
        end
    endfunction

    // Instruction set model that runs from PC zero to halt and queues each out value
    function automatic void execute(logic [31:0] inValue);
        logic [31:0] pc;
        logic [31:0] w;
        logic [4:0]  op;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [31:0] base;
        logic [31:0] addr;
        longint      sa;
        longint      sb;
        logic [63:0] prod;
        bit          running;
        int          steps;
        pc = 32'd0;
        running = 1'b1;
        steps = 0;
        while (running && steps < 4096) begin
            w = shadowMem[pc[addrWidth-1:0]];
            pc = pc + 32'd1;
            steps++;
            op = w[31:27];
            ra = w[26:23];
            rb = w[22:19];
            rc = w[18:15];
            case (op)
                opAdd:  modelRegs[ra] = modelRegs[rb] + modelRegs[rc];
                opSub:  modelRegs[ra] = modelRegs[rb] - modelRegs[rc];
                opAnd:  modelRegs[ra] = modelRegs[rb] & modelRegs[rc];
                opOr:   modelRegs[ra] = modelRegs[rb] | modelRegs[rc];
                opAddi: modelRegs[ra] = modelRegs[rb] + signExtend(w[18:0]);
                opMul: begin
                    sa = longint'($signed(modelRegs[rb]));
                    sb = longint'($signed(modelRegs[rc]));
                    prod = sa * sb;
                    modelHi = prod[63:32];
                    modelLo = prod[31:0];
                end
                opMfhi: modelRegs[ra] = modelHi;
                opMflo: modelRegs[ra] = modelLo;
                opLd, opSt: begin
                    // R0 as base means no base at all
                    base = (rb == 4'd0) ? 32'd0 : modelRegs[rb];
                    addr = base + signExtend(w[18:0]);
                    if (op == opLd) begin
                        modelRegs[ra] = shadowMem[addr[addrWidth-1:0]];
                    end else begin
                        shadowMem[addr[addrWidth-1:0]] = modelRegs[ra];
                    end
                end
                opIn:   modelRegs[ra] = inValue;
                opOut:  expected.push_back(modelRegs[ra]);
                default: running = 1'b0;
            endcase
        end
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= addrWidth'(i);
            progData <= prog[i];
            shadowMem[i] = prog[i];
        end
        @(posedge clk);
        progWe <= 1'b0;
    endtask

    task automatic runProgram(input logic [31:0] inValue);
        int cycles;
        @(posedge clk);
        inPortData <= inValue;
        loadProgram();
        expected.delete();
        execute(inValue);
        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < progLen * 8 + 16) begin
            @(negedge clk);
            cycles++;
        end
        mainChecks++;
        if (!done) begin
            $display("Timed out at %0d ns waiting for done", $time);
            mainErrors++;
        end
        mainChecks++;
        if (expected.size() != 0) begin
            $display("Missing outValid pulses: %0d expected values never came out",
                     expected.size());
            mainErrors++;
        end
    endtask

    task automatic reportTest(input string name);
        int newErrors;
        testCount++;
        newErrors = mainErrors + cmpErrors - startErrors;
        if (newErrors == 0) begin
            $display("Test %0d, %s: ok", testCount, name);
        end else begin
            $display("Test %0d, %s: %0d error(s)", testCount, name, newErrors);
        end
        startErrors = mainErrors + cmpErrors;
    endtask

    task automatic buildAddi();
        logic [31:0] r;
        logic [18:0] c;
        progLen = 0;
        for (int k = 1; k < numRegs; k++) begin
            r = nextRandom();
            c = r[18:0];
            // Odd registers always get a negative constant
            if (k % 2 == 1) c[18] = 1'b1;
            emit(immInstr(opAddi, 4'(k), 4'd0, c));
        end
        for (int k = 1; k < numRegs; k++) begin
            emit(regInstr(opOut, 4'(k), 4'd0, 4'd0));
        end
        emit(regInstr(opHalt, 4'd0, 4'd0, 4'd0));
    endtask

    task automatic buildAluMix();
        logic [31:0] r;
        opcodeT      op;
        logic [3:0]  ra;
        progLen = 0;
        for (int i = 0; i < 24; i++) begin
            r = nextRandom();
            case (r[1:0])
                2'd0:    op = opAdd;
                2'd1:    op = opSub;
                2'd2:    op = opAnd;
                default: op = opOr;
            endcase
            ra = 4'(r[7:4] % 15 + 1);
            emit(regInstr(op, ra, r[11:8], r[15:12]));
        end
        for (int k = 1; k < numRegs; k++) begin
            emit(regInstr(opOut, 4'(k), 4'd0, 4'd0));
        end
        emit(regInstr(opHalt, 4'd0, 4'd0, 4'd0));
    endtask

    task automatic buildMul();
        logic [31:0] r;
        logic [18:0] c;
        progLen = 0;
        for (int i = 0; i < 4; i++) begin
            r = nextRandom();
            c = r[18:0];
            if (i % 2 == 0) c[18] = 1'b1;
            emit(immInstr(opAddi, 4'd1, 4'd0, c));
            r = nextRandom();
            emit(immInstr(opAddi, 4'd2, 4'd0, r[18:0]));
            emit(regInstr(opMul, 4'd0, 4'd1, 4'd2));
            emit(regInstr(opMflo, 4'd5, 4'd0, 4'd0));
            // Wider operand so the high word is more than sign bits
            emit(regInstr(opMul, 4'd0, 4'd5, 4'd1));
            emit(regInstr(opMfhi, 4'd3, 4'd0, 4'd0));
            emit(regInstr(opMflo, 4'd4, 4'd0, 4'd0));
            emit(regInstr(opOut, 4'd3, 4'd0, 4'd0));
            emit(regInstr(opOut, 4'd4, 4'd0, 4'd0));
        end
        emit(regInstr(opHalt, 4'd0, 4'd0, 4'd0));
    endtask

    task automatic buildMemory();
        logic [31:0] r;
        logic [18:0] off;
        logic [18:0] absAddr;
        progLen = 0;
        emit(immInstr(opAddi, 4'd6, 4'd0, 19'd256));
        // R0 now holds 9, which a base address has to ignore
        emit(immInstr(opAddi, 4'd0, 4'd0, 19'd9));
        for (int i = 0; i < 4; i++) begin
            r = nextRandom();
            off = 19'(r[25:19]);
            emit(immInstr(opAddi, 4'd7, 4'd0, r[18:0]));
            emit(immInstr(opSt, 4'd7, 4'd6, off));
            emit(immInstr(opLd, 4'd8, 4'd6, off));
            emit(regInstr(opOut, 4'd8, 4'd0, 4'd0));
            r = nextRandom();
            absAddr = 19'd384 + 19'(r[6:0]);
            emit(immInstr(opAddi, 4'd11, 4'd0, r[25:7]));
            emit(immInstr(opSt, 4'd11, 4'd0, absAddr));
            emit(immInstr(opLd, 4'd9, 4'd6, absAddr - 19'd256));
            emit(regInstr(opOut, 4'd9, 4'd0, 4'd0));
            emit(immInstr(opLd, 4'd10, 4'd0, absAddr));
            emit(regInstr(opOut, 4'd10, 4'd0, 4'd0));
        end
        emit(regInstr(opHalt, 4'd0, 4'd0, 4'd0));
    endtask

    // Outputs sampled on the falling edge
    always @(negedge clk) begin
        if (!rst && outValid) begin
            if (expected.size() == 0) begin
                $display("Unexpected outValid pulse at %0d ns with no value left to check",
                         $time);
                cmpErrors++;
            end else begin
                want = expected.pop_front();
                cmpChecks++;
                if (outPortData !== want) begin
                    $display("** Error at %0d ns: outPortData is %h, expected %h",
                             $time, outPortData, want);
                    cmpErrors++;
                end
            end
        end
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog expired after %0d ns before the tests finished", watchdogNs);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        run        = 1'b0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        inPortData = '0;
        rngState   = 32'd35;
        modelHi    = '0;
        modelLo    = '0;
        cmpChecks  = 0;
        cmpErrors  = 0;
        mainChecks = 0;
        mainErrors = 0;
        testCount  = 0;
        startErrors = 0;
        progLen    = 0;
        for (int i = 0; i < numRegs; i++) begin
            modelRegs[i] = '0;
        end

        @(negedge clk);
        while (rst) @(negedge clk);
        mainChecks++;
        if (done !== 1'b0 || outValid !== 1'b0 || outPortData !== 32'd0) begin
            $display("** Error at %0d ns: after reset done=%b outValid=%b outPortData=%h",
                     $time, done, outValid, outPortData);
            mainErrors++;
        end
        reportTest("reset state");

        buildAddi();
        runProgram(nextRandom());
        reportTest("addi constants");

        buildAluMix();
        runProgram(nextRandom());
        reportTest("add sub and or sequence");

        buildMul();
        runProgram(nextRandom());
        reportTest("mul with mfhi and mflo");

        buildMemory();
        runProgram(nextRandom());
        reportTest("st and ld");

        // Two runs back to back with the second loaded while halted
        progLen = 0;
        r = nextRandom();
        emit(regInstr(opIn, 4'd11, 4'd0, 4'd0));
        emit(regInstr(opOut, 4'd11, 4'd0, 4'd0));
        emit(immInstr(opAddi, 4'd12, 4'd11, {1'b1, r[17:0]}));
        emit(regInstr(opOut, 4'd12, 4'd0, 4'd0));
        emit(regInstr(opHalt, 4'd0, 4'd0, 4'd0));
        runProgram(nextRandom());
        progLen = 0;
        emit(regInstr(opIn, 4'd13, 4'd0, 4'd0));
        emit(regInstr(opOut, 4'd13, 4'd0, 4'd0));
        emit(regInstr(opAdd, 4'd14, 4'd13, 4'd12));
        emit(regInstr(opOut, 4'd14, 4'd0, 4'd0));
        emit(regInstr(opHalt, 4'd0, 4'd0, 4'd0));
        runProgram(nextRandom());
        reportTest("in echo and second run");

        $display("Tests: %0d, checks: %0d, errors: %0d", testCount,
                 mainChecks + cmpChecks, mainErrors + cmpErrors);
        if (mainErrors + cmpErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/isaPkg.sv
rtl/datapathPkg.sv
rtl/alu.sv
rtl/selectEncode.sv
rtl/regFile.sv
rtl/memory.sv
rtl/controlUnit.sv
rtl/datapath.sv
rtl/cpuTop.sv
testbench/clockGen.sv
testbench/cpuTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuTb -f verilog.f -o cpuTb

status=0
./obj_dir/cpuTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit "$status"
fi
echo "Simulation passed"
